// File: dv/float_mul_model.svh
// expected products by the IEEE field rules; truncation only, results assumed normal and in range
`ifndef float_mul_model_svh
`define float_mul_model_svh

// assemble an encoding from its three fields
function automatic float_t pack_float(input logic sign, input exp_t exp_field,
                                      input logic [frac_width-1:0] frac);
    return {sign, exp_field, frac};
endfunction

// full integer product of the two mantissas with their hidden ones
function automatic prod_t mantissa_product(input float_t x, input float_t y);
    prod_t mx;
    prod_t my;
    mx = prod_t'({1'b1, x[frac_width-1:0]});
    my = prod_t'({1'b1, y[frac_width-1:0]});
    return mx * my;
endfunction

// expected truncated single-precision product
function automatic float_t expected_product(input float_t x, input float_t y);
    logic                  sign;
    exp_t                  ex;
    exp_t                  ey;
    prod_t                 full;
    int                    e;
    logic [frac_width-1:0] frac;
    sign = x[float_width-1] ^ y[float_width-1];
    ex = x[float_width-2 -: exp_width];
    ey = y[float_width-2 -: exp_width];
    // zero exponent field flushes to an all-zero word
    if (ex == '0 || ey == '0) begin
        return '0;
    end
    full = mantissa_product(x, y);
    e = int'(ex) + int'(ey) - exp_bias;
    if (full[prod_width-1]) begin
        // product in [2, 4), shift down by one
        e = e + 1;
        frac = full[prod_width-2 -: frac_width];
    end else begin
        frac = full[prod_width-3 -: frac_width];
    end
    return pack_float(sign, e[exp_width-1:0], frac);
endfunction

`endif

// File: dv/float_mul_tb.sv
// directed and seeded random checks of the float multiplier; expects a fixed 14-cycle latency
`timescale 1ns/10ps

module float_mul_tb import float_mul_pkg::*; ();

    localparam int latency = 14;
    localparam int ack_wait_limit = 30;
    localparam int num_random = 200;
    localparam int num_ops = 3 + 4 + 5 + num_random + 2;
    localparam int timeout_cycles = num_ops * 16 + 200;

    // encodings used by the directed tests
    localparam float_t one_0 = 32'h3F80_0000;
    localparam float_t one_5 = 32'h3FC0_0000;
    localparam float_t two_0 = 32'h4000_0000;
    localparam float_t three_0 = 32'h4040_0000;

    logic   clk;
    logic   rst;
    logic   req;
    float_t a;
    float_t b;
    float_t out;
    logic   ack;

    int cyc = 0;
    int value_errors = 0;
    int timing_errors = 0;
    int protocol_errors = 0;

    `include "float_mul_model.svh"

    float_mul_pipeline uut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .a   (a),
        .b   (b),
        .out (out),
        .ack (ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycle count and watchdog
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare_float(input string name, input float_t got, input float_t expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic verify_latency(input int got);
        if (got != latency) begin
            $display("FAILED latency: got 0x%0h expected 0x%0h", got, latency);
            timing_errors++;
        end
    endtask

    task automatic check_ack_count(input int got, input int expected);
        if (got != expected) begin
            $display("FAILED ack_count: got 0x%0h expected 0x%0h", got, expected);
            protocol_errors++;
        end
    endtask

    // one req strobe, then wait for ack on falling edges where outputs are settled
    task automatic issue_op(input float_t x, input float_t y,
                            output int cycles, output float_t result);
        int start;
        int n;
        cycles = -1;
        result = '0;
        @(posedge clk);
        req <= 1'b1;
        a <= x;
        b <= y;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        start = cyc;
        for (n = 0; n < ack_wait_limit; n++) begin
            @(negedge clk);
            if (ack) begin
                cycles = cyc - start;
                result = out;
                break;
            end
        end
        if (cycles < 0) begin
            $display("no ack within %0d cycles of req for a=0x%08h b=0x%08h",
                     ack_wait_limit, x, y);
            protocol_errors++;
        end
    endtask

    task automatic run_and_compare(input float_t x, input float_t y, input float_t expected);
        int     cycles;
        float_t result;
        issue_op(x, y, cycles, result);
        if (cycles >= 0) begin
            compare_float("out", result, expected);
            verify_latency(cycles);
        end
    endtask

    task automatic idle_after_reset();
        int acks;
        acks = 0;
        repeat (10) begin
            @(negedge clk);
            if (ack) begin
                acks++;
            end
            compare_float("out", out, '0);
        end
        check_ack_count(acks, 0);
    endtask

    task automatic exact_products();
        run_and_compare(one_0, one_0, 32'h3F80_0000);
        run_and_compare(two_0, three_0, 32'h40C0_0000);
        run_and_compare(one_5, one_5, 32'h4010_0000);
    endtask

    // 2.0 x 3.0 under all four sign pairs
    task automatic sign_combinations();
        float_t x;
        float_t y;
        float_t expected;
        for (int s = 0; s < 4; s++) begin
            x = {s[1], two_0[float_width-2:0]};
            y = {s[0], three_0[float_width-2:0]};
            expected = {s[1] ^ s[0], 31'h40C0_0000};
            run_and_compare(x, y, expected);
        end
    endtask

    task automatic zero_operands();
        run_and_compare(32'h0000_0000, three_0, '0);
        run_and_compare(three_0, 32'h0000_0000, '0);
        // subnormals count as zero
        run_and_compare(32'h0001_2345, two_0, '0);
        run_and_compare(one_5, 32'h807F_FFFF, '0);
        run_and_compare(32'h8000_0000, 32'h8000_0000, '0);
    endtask

    // exponent fields in 64..190 keep the result exponent in 1..254
    task automatic random_normals();
        float_t x;
        float_t y;
        int     high_cases;
        high_cases = 0;
        for (int i = 0; i < num_random; i++) begin
            x = pack_float(1'($urandom), exp_t'($urandom_range(190, 64)),
                           frac_width'($urandom));
            y = pack_float(1'($urandom), exp_t'($urandom_range(190, 64)),
                           frac_width'($urandom));
            if (mantissa_product(x, y) >= prod_t'(1) << (prod_width - 1)) begin
                high_cases++;
            end
            run_and_compare(x, y, expected_product(x, y));
        end
        if (high_cases == 0 || high_cases == num_random) begin
            $display("random operands hit only one normalization case (%0d of %0d high)",
                     high_cases, num_random);
            protocol_errors++;
        end
    endtask

    // second req four cycles in must be dropped
    task automatic request_while_busy();
        int     acks;
        float_t result;
        acks = 0;
        result = '0;
        @(posedge clk);
        req <= 1'b1;
        a <= one_5;
        b <= two_0;
        @(posedge clk);
        req <= 1'b0;
        repeat (3) @(posedge clk);
        req <= 1'b1;
        a <= three_0;
        b <= three_0;
        @(posedge clk);
        req <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (ack) begin
                acks++;
                result = out;
            end
        end
        check_ack_count(acks, 1);
        compare_float("out", result, expected_product(one_5, two_0));
    endtask

    initial begin
        void'($urandom(43));
        rst = 1'b1;
        req = 1'b0;
        a = '0;
        b = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        idle_after_reset();
        exact_products();
        sign_combinations();
        zero_operands();
        random_normals();
        request_while_busy();

        $display("errors: value %0d, timing %0d, protocol %0d",
                 value_errors, timing_errors, protocol_errors);
        if (value_errors + timing_errors + protocol_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
rtl/float_mul_pkg.sv
rtl/float_operand_unpack.sv
rtl/mant_mul_2bpc.sv
rtl/float_result_pack.sv
rtl/float_mul_pipeline.sv
dv/float_mul_tb.sv

// File: rtl/float_mul_pipeline.sv
// fixed 14-cycle req-to-ack latency; req while an operation is in flight is ignored
`timescale 1ns/10ps

module float_mul_pipeline import float_mul_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   req,
    input  float_t a,
    input  float_t b,
    output float_t out,
    output logic   ack
);

    logic      op_valid;
    operands_t op;
    logic      prod_valid;
    product_t  prod;

    // ack doubles as the busy release of the input side
    float_operand_unpack u_unpack (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .a        (a),
        .b        (b),
        .ack      (ack),
        .op_valid (op_valid),
        .op       (op)
    );

    mant_mul_2bpc u_mul (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .prod_valid (prod_valid),
        .prod       (prod)
    );

    float_result_pack u_pack (
        .clk        (clk),
        .rst        (rst),
        .prod_valid (prod_valid),
        .prod       (prod),
        .out        (out),
        .ack        (ack)
    );

endmodule

// File: rtl/float_mul_pkg.sv
// shared widths and types for the float multiplier; IEEE-754 single precision only, no NaN/inf
package float_mul_pkg;

    // encoding layout
    localparam int float_width = 32;
    localparam int exp_width = 8;
    localparam int frac_width = 23;
    localparam int exp_bias = 127;

    // mantissa with the hidden one, and the full product
    localparam int mant_width = frac_width + 1;
    localparam int prod_width = 2 * mant_width;

    // iterative core retires this many multiplier bits per step
    localparam int bits_per_cycle = 2;
    localparam int mul_steps = mant_width / bits_per_cycle;

    typedef logic [float_width-1:0] float_t;
    typedef logic [exp_width-1:0] exp_t;
    typedef logic [mant_width-1:0] mant_t;
    typedef logic [prod_width-1:0] prod_t;

    // two extra bits of headroom over the field, signed for the bias subtraction
    typedef logic signed [exp_width+1:0] exp_sum_t;

    typedef logic [$clog2(mul_steps)-1:0] step_cnt_t;

    // unpacked operand pair handed to the mantissa core
    typedef struct packed {
        logic     sign;
        exp_sum_t exp_sum;
        logic     zero;
        mant_t    a_mant;
        mant_t    b_mant;
    } operands_t;

    // core result, sign/exponent/zero pass through untouched
    typedef struct packed {
        logic     sign;
        exp_sum_t exp_sum;
        logic     zero;
        prod_t    prod;
    } product_t;

endpackage

// File: rtl/float_operand_unpack.sv
// one operation in flight; req while busy is dropped and a zero exponent field counts as zero
`timescale 1ns/10ps

module float_operand_unpack import float_mul_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  float_t    a,
    input  float_t    b,
    input  logic      ack,
    output logic      op_valid,
    output operands_t op
);

    logic                  busy;
    logic                  accept;
    logic                  a_sign;
    logic                  b_sign;
    exp_t                  a_exp;
    exp_t                  b_exp;
    logic [frac_width-1:0] a_frac;
    logic [frac_width-1:0] b_frac;
    exp_sum_t              exp_sum;

    assign accept = req && !busy;

    // field split of both encodings
    assign {a_sign, a_exp, a_frac} = a;
    assign {b_sign, b_exp, b_frac} = b;

    // one bias has to come out of the sum
    assign exp_sum = exp_sum_t'(a_exp) + exp_sum_t'(b_exp) - exp_sum_t'(exp_bias);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            op_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (ack) begin
                // result delivered so the next req can start
                busy <= 1'b0;
            end
        end
    end

    // operand payload held until the next accepted req
    always_ff @(posedge clk) begin
        if (accept) begin
            op.sign <= a_sign ^ b_sign;
            op.exp_sum <= exp_sum;
            op.zero <= (a_exp == '0) || (b_exp == '0);
            op.a_mant <= {1'b1, a_frac};
            op.b_mant <= {1'b1, b_frac};
        end
    end

    // the result side only acks an operation that this side started
    a_ack_when_busy: assert property (
        @(posedge clk) disable iff (rst) ack |-> busy
    );

endmodule

// File: rtl/float_result_pack.sv
// truncates the fraction, no rounding; exponent field only defined for results in 1..254
`timescale 1ns/10ps

module float_result_pack import float_mul_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     prod_valid,
    input  product_t prod,
    output float_t   out,
    output logic     ack
);

    logic                  top_bit;
    exp_sum_t              norm_exp;
    logic [frac_width-1:0] frac;
    float_t                word;

    // product of two 1.x mantissas is in [1, 4)
    assign top_bit = prod.prod[prod_width-1];

    assign norm_exp = top_bit ? prod.exp_sum + exp_sum_t'(1) : prod.exp_sum;

    // drop the leading one, keep the next 23 bits
    assign frac = top_bit ? prod.prod[prod_width-2 -: frac_width]
                          : prod.prod[prod_width-3 -: frac_width];

    assign word = prod.zero ? '0 : {prod.sign, norm_exp[exp_width-1:0], frac};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
            ack <= 1'b0;
        end else begin
            ack <= prod_valid;
            // out reads zero outside the ack cycle
            out <= prod_valid ? word : '0;
        end
    end

    // hidden ones from the front end guarantee a leading one in the top two bits
    a_normalized: assert property (
        @(posedge clk) disable iff (rst)
        (prod_valid && !prod.zero) |-> (prod.prod[prod_width-1] || prod.prod[prod_width-2])
    );

endmodule

// File: rtl/mant_mul_2bpc.sv
// 24x24 shift-add multiplier, fixed mul_steps iterations even for zero operands
`timescale 1ns/10ps

module mant_mul_2bpc import float_mul_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      op_valid,
    input  operands_t op,
    output logic      prod_valid,
    output product_t  prod
);

    logic                  running;
    step_cnt_t             step;
    mant_t                 mcand;
    mant_t                 mplier;
    prod_t                 acc;
    logic [mant_width+1:0] pp;
    logic [mant_width+1:0] upper;
    logic                  sign_q;
    exp_sum_t              exp_sum_q;
    logic                  zero_q;

    // multiplicand times the current 2-bit digit
    always_comb begin
        case (mplier[bits_per_cycle-1:0])
            2'd1: pp = {2'b00, mcand};
            2'd2: pp = {1'b0, mcand, 1'b0};
            2'd3: pp = {2'b00, mcand} + {1'b0, mcand, 1'b0};
            default: pp = '0;
        endcase
    end

    // partial product lands on the high half, cannot exceed 26 bits
    assign upper = {2'b00, acc[prod_width-1:mant_width]} + pp;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            step <= '0;
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= 1'b0;
            if (op_valid) begin
                running <= 1'b1;
                step <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                // last digit consumed this edge
                if (step == step_cnt_t'(mul_steps - 1)) begin
                    running <= 1'b0;
                    prod_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            acc <= '0;
            mcand <= op.a_mant;
            mplier <= op.b_mant;
            sign_q <= op.sign;
            exp_sum_q <= op.exp_sum;
            zero_q <= op.zero;
        end else if (running) begin
            // low two product bits are final, shift them down out of the adder
            acc <= {upper, acc[mant_width-1:bits_per_cycle]};
            mplier <= mplier >> bits_per_cycle;
        end
    end

    assign prod = '{
        sign: sign_q,
        exp_sum: exp_sum_q,
        zero: zero_q,
        prod: acc
    };

    // the front end must not restart the core mid-product
    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst) op_valid |-> !running
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module float_mul_tb \
    -f filelist.f \
    -o float_mul_sim

./obj_dir/float_mul_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
